// ==== hdl/mips_isa_pkg.sv ====
package mips_isa_pkg;

    // primary opcodes, bits 31:26
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_j       = 6'h02;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_bne     = 6'h05;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_andi    = 6'h0c;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_lui     = 6'h0f;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_sw      = 6'h2b;

    // funct codes under op_special
    localparam logic [5:0] fn_sll  = 6'h00;
    localparam logic [5:0] fn_srl  = 6'h02;
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_xor  = 6'h26;
    localparam logic [5:0] fn_slt  = 6'h2a;

    // register format
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fmt_t;

    // immediate format
    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fmt_t;

    // jump format, target is a word index
    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target;
    } j_fmt_t;

    // one instruction word, three views
    // opcode sits in the same bits in every view
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        j_fmt_t j;
    } instr_u;

endpackage

// ==== hdl/mycpu_pkg.sv ====
package mycpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  rwen_t;
    typedef logic [4:0]  creg_addr_t;

    // boot address of the core
    localparam word_t reset_pc = 32'hbfc00000;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sll,
        alu_srl,
        alu_lui
    } alu_op_e;

    // decoded control for one instruction
    typedef struct packed {
        alu_op_e alu_op;
        logic    use_imm;
        logic    zero_ext;
        logic    use_shamt;
        logic    mem_read;
        logic    mem_write;
        logic    reg_write;
        logic    dst_rd;
        logic    branch_eq;
        logic    branch_ne;
        logic    jump;
    } ctrl_t;

    // one pass through all five is one instruction
    typedef enum logic [2:0] {
        s_fetch,
        s_decode,
        s_execute,
        s_memory,
        s_writeback
    } state_e;

endpackage

// ==== hdl/cpu_ifs.sv ====
`timescale 1ns/1ps

// fixed-latency sram port
// rdata shows up the cycle after en
interface mem_port_if;
    logic              en;
    mycpu_pkg::rwen_t  wen;
    mycpu_pkg::word_t  addr;
    mycpu_pkg::word_t  wdata;
    mycpu_pkg::word_t  rdata;

    // core side
    modport master (
        output en,
        output wen,
        output addr,
        output wdata,
        input  rdata
    );

    // memory side
    modport slave (
        input  en,
        input  wen,
        input  addr,
        input  wdata,
        output rdata
    );
endinterface

// two read ports, one write port
interface regfile_if;
    mycpu_pkg::creg_addr_t raddr1;
    mycpu_pkg::creg_addr_t raddr2;
    mycpu_pkg::word_t      rdata1;
    mycpu_pkg::word_t      rdata2;
    logic                  wen;
    mycpu_pkg::creg_addr_t waddr;
    mycpu_pkg::word_t      wdata;

    modport client (
        output raddr1,
        output raddr2,
        input  rdata1,
        input  rdata2,
        output wen,
        output waddr,
        output wdata
    );

    modport server (
        input  raddr1,
        input  raddr2,
        output rdata1,
        output rdata2,
        input  wen,
        input  waddr,
        input  wdata
    );
endinterface

// ==== hdl/regfile.sv ====
`timescale 1ns/1ps

module regfile (
    input logic       clk,
    input logic       rst_n,
    regfile_if.server rf
);

    mycpu_pkg::word_t regs [32];

    // write port, $0 is never stored
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rf.wen && rf.waddr != '0) begin
            regs[rf.waddr] <= rf.wdata;
        end
    end

    // reads are combinational
    // $0 reads zero since its slot stays clear
    assign rf.rdata1 = regs[rf.raddr1];
    assign rf.rdata2 = regs[rf.raddr2];

    // $0 storage must stay zero across any write sequence
    a_reg0_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        regs[0] == '0
    );

endmodule

// ==== hdl/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  mycpu_pkg::alu_op_e op,
    input  mycpu_pkg::word_t   a,
    input  mycpu_pkg::word_t   b,
    output mycpu_pkg::word_t   result,
    output logic               zero
);

    always_comb begin
        case (op)
            mycpu_pkg::alu_add: begin
                result = a + b;
            end
            mycpu_pkg::alu_sub: begin
                result = a - b;
            end
            mycpu_pkg::alu_and: begin
                result = a & b;
            end
            mycpu_pkg::alu_or: begin
                result = a | b;
            end
            mycpu_pkg::alu_xor: begin
                result = a ^ b;
            end
            mycpu_pkg::alu_slt: begin
                // signed compare
                result = {31'b0, $signed(a) < $signed(b)};
            end
            // shifts move b, amount comes in on a[4:0]
            mycpu_pkg::alu_sll: begin
                result = b << a[4:0];
            end
            mycpu_pkg::alu_srl: begin
                result = b >> a[4:0];
            end
            mycpu_pkg::alu_lui: begin
                // immediate into the upper half
                result = {b[15:0], 16'b0};
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // branches compare with alu_sub, equal gives zero
    assign zero = (result == '0);

endmodule

// ==== hdl/decoder.sv ====
`timescale 1ns/1ps

module decoder (
    input  mips_isa_pkg::instr_u instr,
    output mycpu_pkg::ctrl_t     ctrl,
    output logic                 illegal
);

    always_comb begin
        // anything unknown falls through as a no-op
        ctrl    = '0;
        illegal = 1'b0;
        case (instr.r.opcode)
            mips_isa_pkg::op_special: begin
                ctrl.reg_write = 1'b1;
                ctrl.dst_rd    = 1'b1;
                case (instr.r.funct)
                    mips_isa_pkg::fn_addu: ctrl.alu_op = mycpu_pkg::alu_add;
                    mips_isa_pkg::fn_subu: ctrl.alu_op = mycpu_pkg::alu_sub;
                    mips_isa_pkg::fn_and:  ctrl.alu_op = mycpu_pkg::alu_and;
                    mips_isa_pkg::fn_or:   ctrl.alu_op = mycpu_pkg::alu_or;
                    mips_isa_pkg::fn_xor:  ctrl.alu_op = mycpu_pkg::alu_xor;
                    mips_isa_pkg::fn_slt:  ctrl.alu_op = mycpu_pkg::alu_slt;
                    mips_isa_pkg::fn_sll: begin
                        ctrl.alu_op    = mycpu_pkg::alu_sll;
                        ctrl.use_shamt = 1'b1;
                    end
                    mips_isa_pkg::fn_srl: begin
                        ctrl.alu_op    = mycpu_pkg::alu_srl;
                        ctrl.use_shamt = 1'b1;
                    end
                    default: begin
                        ctrl    = '0;
                        illegal = 1'b1;
                    end
                endcase
            end
            mips_isa_pkg::op_addiu: begin
                ctrl.alu_op    = mycpu_pkg::alu_add;
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            // logical immediates are zero extended
            mips_isa_pkg::op_andi: begin
                ctrl.alu_op    = mycpu_pkg::alu_and;
                ctrl.use_imm   = 1'b1;
                ctrl.zero_ext  = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            mips_isa_pkg::op_ori: begin
                ctrl.alu_op    = mycpu_pkg::alu_or;
                ctrl.use_imm   = 1'b1;
                ctrl.zero_ext  = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            mips_isa_pkg::op_lui: begin
                ctrl.alu_op    = mycpu_pkg::alu_lui;
                ctrl.use_imm   = 1'b1;
                ctrl.zero_ext  = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            // address = base + signed offset
            mips_isa_pkg::op_lw: begin
                ctrl.alu_op    = mycpu_pkg::alu_add;
                ctrl.use_imm   = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            mips_isa_pkg::op_sw: begin
                ctrl.alu_op    = mycpu_pkg::alu_add;
                ctrl.use_imm   = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            // rs - rt, the zero flag decides
            mips_isa_pkg::op_beq: begin
                ctrl.alu_op    = mycpu_pkg::alu_sub;
                ctrl.branch_eq = 1'b1;
            end
            mips_isa_pkg::op_bne: begin
                ctrl.alu_op    = mycpu_pkg::alu_sub;
                ctrl.branch_ne = 1'b1;
            end
            mips_isa_pkg::op_j: begin
                ctrl.jump = 1'b1;
            end
            default: begin
                illegal = 1'b1;
            end
        endcase
    end

endmodule

// ==== hdl/datapath.sv ====
`timescale 1ns/1ps

module datapath (
    input  logic             clk,
    input  logic             rst_n,
    mem_port_if.master       imem,
    mem_port_if.master       dmem,
    regfile_if.client        rf,
    output mycpu_pkg::word_t wb_pc
);

    mycpu_pkg::state_e    state;
    logic                 running;
    mycpu_pkg::word_t     pc;
    mycpu_pkg::word_t     npc;
    mips_isa_pkg::instr_u ir;
    mips_isa_pkg::instr_u fetched;
    mycpu_pkg::word_t     a_q;
    mycpu_pkg::word_t     b_q;
    mycpu_pkg::word_t     alu_q;
    mycpu_pkg::ctrl_t     ctrl;
    logic                 illegal;
    mycpu_pkg::word_t     imm_ext;
    mycpu_pkg::word_t     alu_a;
    mycpu_pkg::word_t     alu_b;
    mycpu_pkg::word_t     alu_y;
    logic                 alu_zero;
    logic                 taken;
    mycpu_pkg::word_t     pc_plus4;
    mycpu_pkg::word_t     br_target;
    mycpu_pkg::word_t     j_target;

    // sequencer, held in fetch for one cycle out of reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            running <= 1'b0;
            state   <= mycpu_pkg::s_fetch;
        end else begin
            running <= 1'b1;
            if (running) begin
                case (state)
                    mycpu_pkg::s_fetch:     state <= mycpu_pkg::s_decode;
                    mycpu_pkg::s_decode:    state <= mycpu_pkg::s_execute;
                    mycpu_pkg::s_execute:   state <= mycpu_pkg::s_memory;
                    mycpu_pkg::s_memory:    state <= mycpu_pkg::s_writeback;
                    default:                state <= mycpu_pkg::s_fetch;
                endcase
            end
        end
    end

    // pc only moves at the end of writeback
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= mycpu_pkg::reset_pc;
        end else if (state == mycpu_pkg::s_writeback) begin
            pc <= npc;
        end
    end

    // fetch, read-only instruction side
    assign imem.en    = running && (state == mycpu_pkg::s_fetch);
    assign imem.addr  = pc;
    assign imem.wen   = '0;
    assign imem.wdata = '0;

    // instruction word is on rdata during decode
    assign fetched   = imem.rdata;
    assign rf.raddr1 = fetched.i.rs;
    assign rf.raddr2 = fetched.i.rt;

    // decode latches the word and both operands
    always_ff @(posedge clk) begin
        if (state == mycpu_pkg::s_decode) begin
            ir  <= fetched;
            a_q <= rf.rdata1;
            b_q <= rf.rdata2;
        end
    end

    decoder u_decoder (
        .instr   (ir),
        .ctrl    (ctrl),
        .illegal (illegal)
    );

    assign imm_ext = ctrl.zero_ext ? {16'b0, ir.i.imm} : {{16{ir.i.imm[15]}}, ir.i.imm};
    assign alu_a   = ctrl.use_shamt ? {27'b0, ir.r.shamt} : a_q;
    assign alu_b   = ctrl.use_imm ? imm_ext : b_q;

    alu u_alu (
        .op     (ctrl.alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_y),
        .zero   (alu_zero)
    );

    // next pc candidates, no delay slot
    assign pc_plus4  = pc + 32'd4;
    assign br_target = pc_plus4 + {{14{ir.i.imm[15]}}, ir.i.imm, 2'b00};
    assign j_target  = {pc_plus4[31:28], ir.j.target, 2'b00};
    assign taken     = (ctrl.branch_eq && alu_zero) || (ctrl.branch_ne && !alu_zero);

    // execute keeps the result and resolves the next pc
    always_ff @(posedge clk) begin
        if (state == mycpu_pkg::s_execute) begin
            alu_q <= alu_y;
            if (ctrl.jump) begin
                npc <= j_target;
            end else if (taken) begin
                npc <= br_target;
            end else begin
                npc <= pc_plus4;
            end
        end
    end

    // data access in s_memory only, stores write the whole word
    assign dmem.en    = (state == mycpu_pkg::s_memory) && (ctrl.mem_read || ctrl.mem_write);
    assign dmem.wen   = ((state == mycpu_pkg::s_memory) && ctrl.mem_write) ? 4'hf : 4'h0;
    assign dmem.addr  = alu_q;
    assign dmem.wdata = b_q;

    // load data lands during writeback and goes straight into the file
    assign rf.wen   = (state == mycpu_pkg::s_writeback) && ctrl.reg_write;
    assign rf.waddr = ctrl.dst_rd ? ir.r.rd : ir.i.rt;
    assign rf.wdata = ctrl.mem_read ? dmem.rdata : alu_q;

    // pc still names the committing instruction here
    assign wb_pc = pc;

    a_state_legal: assert property (
        @(posedge clk) disable iff (!rst_n)
        state inside {mycpu_pkg::s_fetch, mycpu_pkg::s_decode, mycpu_pkg::s_execute,
                      mycpu_pkg::s_memory, mycpu_pkg::s_writeback}
    );

    a_dmem_in_memory: assert property (
        @(posedge clk) disable iff (!rst_n)
        dmem.en |-> state == mycpu_pkg::s_memory
    );

    // the latched word must be one the decoder knows
    a_no_illegal: assert property (
        @(posedge clk) disable iff (!rst_n)
        state == mycpu_pkg::s_execute |-> !illegal
    );

endmodule

// ==== hdl/mycpu_top.sv ====
`timescale 1ns/1ps

module mycpu_top (
    input  logic                  clk,
    input  logic                  rst_n,

    output logic                  inst_sram_en,
    output mycpu_pkg::rwen_t      inst_sram_wen,
    output mycpu_pkg::word_t      inst_sram_addr,
    output mycpu_pkg::word_t      inst_sram_wdata,
    input  mycpu_pkg::word_t      inst_sram_rdata,

    output logic                  data_sram_en,
    output mycpu_pkg::rwen_t      data_sram_wen,
    output mycpu_pkg::word_t      data_sram_addr,
    output mycpu_pkg::word_t      data_sram_wdata,
    input  mycpu_pkg::word_t      data_sram_rdata,

    // commit trace
    output mycpu_pkg::word_t      debug_wb_pc,
    output mycpu_pkg::rwen_t      debug_wb_rf_wen,
    output mycpu_pkg::creg_addr_t debug_wb_rf_wnum,
    output mycpu_pkg::word_t      debug_wb_rf_wdata
);

    mem_port_if imem ();
    mem_port_if dmem ();
    regfile_if  rf ();

    datapath u_datapath (
        .clk   (clk),
        .rst_n (rst_n),
        .imem  (imem.master),
        .dmem  (dmem.master),
        .rf    (rf.client),
        .wb_pc (debug_wb_pc)
    );

    regfile u_regfile (
        .clk   (clk),
        .rst_n (rst_n),
        .rf    (rf.server)
    );

    // instruction side, write strobe and data come in as zero
    assign inst_sram_en    = imem.en;
    assign inst_sram_wen   = imem.wen;
    assign inst_sram_addr  = imem.addr;
    assign inst_sram_wdata = imem.wdata;
    assign imem.rdata      = inst_sram_rdata;

    assign data_sram_en    = dmem.en;
    assign data_sram_wen   = dmem.wen;
    assign data_sram_addr  = dmem.addr;
    assign data_sram_wdata = dmem.wdata;
    assign dmem.rdata      = data_sram_rdata;

    // trace taps the write port, $0 writes show as no write
    assign debug_wb_rf_wen   = {4{rf.wen && (rf.waddr != '0)}};
    assign debug_wb_rf_wnum  = rf.waddr;
    assign debug_wb_rf_wdata = rf.wdata;

    // word accesses only
    a_data_aligned: assert property (
        @(posedge clk) disable iff (!rst_n)
        data_sram_en |-> data_sram_addr[1:0] == 2'b00
    );

endmodule

// ==== dv/tb_mycpu.sv ====
`timescale 1ns/1ps

module tb_mycpu;

    localparam int prog_len   = 160;
    localparam int gap_limit  = 8;
    localparam int boot_limit = 10;

    // expected effect of one instruction
    typedef struct packed {
        logic [31:0] pc;
        logic        wr;
        logic [4:0]  wnum;
        logic [31:0] wdata;
        logic        ld;
        logic        st;
        logic [31:0] mem_addr;
        logic [31:0] mem_data;
    } commit_t;

    logic                  clk;
    logic                  rst_n;
    logic                  inst_sram_en;
    mycpu_pkg::rwen_t      inst_sram_wen;
    mycpu_pkg::word_t      inst_sram_addr;
    mycpu_pkg::word_t      inst_sram_wdata;
    mycpu_pkg::word_t      inst_sram_rdata;
    logic                  data_sram_en;
    mycpu_pkg::rwen_t      data_sram_wen;
    mycpu_pkg::word_t      data_sram_addr;
    mycpu_pkg::word_t      data_sram_wdata;
    mycpu_pkg::word_t      data_sram_rdata;
    mycpu_pkg::word_t      debug_wb_pc;
    mycpu_pkg::rwen_t      debug_wb_rf_wen;
    mycpu_pkg::creg_addr_t debug_wb_rf_wnum;
    mycpu_pkg::word_t      debug_wb_rf_wdata;

    // sram contents with the instruction side indexed by addr[11:2]
    logic [31:0] imem_words [1024];
    logic [31:0] dmem_words [256];

    // reference state
    logic [31:0] model_regs [32];
    logic [31:0] model_dmem [256];
    logic [31:0] model_pc;

    mycpu_top i_mycpu_top (
        .clk               (clk),
        .rst_n             (rst_n),
        .inst_sram_en      (inst_sram_en),
        .inst_sram_wen     (inst_sram_wen),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_wdata   (inst_sram_wdata),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_en      (data_sram_en),
        .data_sram_wen     (data_sram_wen),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // instruction sram with one cycle read latency
    always @(posedge clk) begin
        if (inst_sram_en) begin
            inst_sram_rdata <= #1 imem_words[inst_sram_addr[11:2]];
        end
    end

    // data sram with byte enables
    // a read returns the old word
    always @(posedge clk) begin
        if (data_sram_en) begin
            for (int b = 0; b < 4; b++) begin
                if (data_sram_wen[b]) begin
                    dmem_words[data_sram_addr[9:2]][8*b +: 8] <= data_sram_wdata[8*b +: 8];
                end
            end
            data_sram_rdata <= #1 dmem_words[data_sram_addr[9:2]];
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("error: %s got 0x%08h expected 0x%08h", name, got, exp);
            $display("Test failed");
            $fatal(1, "simulation stopped on first error");
        end
    endtask

    // one random instruction at program slot idx
    // branches and jumps only go forward and never past the final jump
    function automatic logic [31:0] random_instr(input int idx, input int last);
        mips_isa_pkg::instr_u ins;
        int          kind;
        int          room;
        int          hop;
        logic [31:0] tgt;
        ins = '0;
        kind = $urandom % 100;
        room = last - idx - 1;
        hop = $urandom % ((room < 3) ? room + 1 : 4);
        ins.r.rs = $urandom % 16;
        ins.r.rt = $urandom % 16;
        if (kind < 35) begin
            ins.r.opcode = mips_isa_pkg::op_special;
            ins.r.rd = $urandom % 16;
            case ($urandom % 8)
                0: ins.r.funct = mips_isa_pkg::fn_addu;
                1: ins.r.funct = mips_isa_pkg::fn_subu;
                2: ins.r.funct = mips_isa_pkg::fn_and;
                3: ins.r.funct = mips_isa_pkg::fn_or;
                4: ins.r.funct = mips_isa_pkg::fn_xor;
                5: ins.r.funct = mips_isa_pkg::fn_slt;
                6: ins.r.funct = mips_isa_pkg::fn_sll;
                default: ins.r.funct = mips_isa_pkg::fn_srl;
            endcase
            if (ins.r.funct == mips_isa_pkg::fn_sll || ins.r.funct == mips_isa_pkg::fn_srl) begin
                ins.r.shamt = $urandom % 32;
            end
        end else if (kind < 55) begin
            ins.i.imm = $urandom;
            case ($urandom % 4)
                0: ins.i.opcode = mips_isa_pkg::op_addiu;
                1: ins.i.opcode = mips_isa_pkg::op_andi;
                2: ins.i.opcode = mips_isa_pkg::op_ori;
                default: begin
                    ins.i.opcode = mips_isa_pkg::op_lui;
                    ins.i.rs = '0;
                end
            endcase
        end else if (kind < 75) begin
            // base $0 and an aligned word in the low 32 words
            ins.i.opcode = (kind < 65) ? mips_isa_pkg::op_sw : mips_isa_pkg::op_lw;
            ins.i.rs = '0;
            ins.i.imm = {9'b0, 5'($urandom % 32), 2'b00};
        end else if (kind < 85) begin
            ins.i.opcode = (kind < 80) ? mips_isa_pkg::op_beq : mips_isa_pkg::op_bne;
            ins.i.rs = $urandom % 8;
            ins.i.rt = ($urandom % 3 == 0) ? ins.i.rs : 5'($urandom % 8);
            ins.i.imm = hop;
        end else if (kind < 90) begin
            tgt = mycpu_pkg::reset_pc + 4 * (idx + 1 + hop);
            ins.j.opcode = mips_isa_pkg::op_j;
            ins.j.target = tgt[27:2];
        end else begin
            ins.i.opcode = mips_isa_pkg::op_addiu;
            ins.i.imm = $urandom;
        end
        return ins;
    endfunction

    // isa model stepping one instruction per call
    function automatic commit_t ref_step(input logic [31:0] word);
        mips_isa_pkg::instr_u ins;
        commit_t              c;
        logic [31:0]          a;
        logic [31:0]          b;
        logic [31:0]          simm;
        logic [31:0]          pc4;
        logic [31:0]          next_pc;
        logic [31:0]          res;
        logic [4:0]           dst;
        logic                 wr;
        ins = word;
        c = '0;
        c.pc = model_pc;
        a = model_regs[ins.r.rs];
        b = model_regs[ins.r.rt];
        simm = {{16{ins.i.imm[15]}}, ins.i.imm};
        pc4 = model_pc + 32'd4;
        next_pc = pc4;
        res = '0;
        wr = 1'b1;
        dst = ins.i.rt;
        case (ins.r.opcode)
            mips_isa_pkg::op_special: begin
                dst = ins.r.rd;
                case (ins.r.funct)
                    mips_isa_pkg::fn_addu: res = a + b;
                    mips_isa_pkg::fn_subu: res = a - b;
                    mips_isa_pkg::fn_and:  res = a & b;
                    mips_isa_pkg::fn_or:   res = a | b;
                    mips_isa_pkg::fn_xor:  res = a ^ b;
                    mips_isa_pkg::fn_slt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    mips_isa_pkg::fn_sll:  res = b << ins.r.shamt;
                    default:               res = b >> ins.r.shamt;
                endcase
            end
            mips_isa_pkg::op_addiu: res = a + simm;
            mips_isa_pkg::op_andi:  res = a & {16'h0, ins.i.imm};
            mips_isa_pkg::op_ori:   res = a | {16'h0, ins.i.imm};
            mips_isa_pkg::op_lui:   res = {ins.i.imm, 16'h0};
            mips_isa_pkg::op_lw: begin
                c.ld = 1'b1;
                c.mem_addr = a + simm;
                res = model_dmem[c.mem_addr[9:2]];
            end
            mips_isa_pkg::op_sw: begin
                wr = 1'b0;
                c.st = 1'b1;
                c.mem_addr = a + simm;
                c.mem_data = b;
                model_dmem[c.mem_addr[9:2]] = b;
            end
            mips_isa_pkg::op_beq, mips_isa_pkg::op_bne: begin
                wr = 1'b0;
                // no delay slot so the target is relative to pc + 4
                if ((a == b) == (ins.i.opcode == mips_isa_pkg::op_beq)) begin
                    next_pc = pc4 + {simm[29:0], 2'b00};
                end
            end
            default: begin
                wr = 1'b0;
                next_pc = {pc4[31:28], ins.j.target, 2'b00};
            end
        endcase
        if (wr && dst != 5'd0) begin
            model_regs[dst] = res;
            c.wr = 1'b1;
            c.wnum = dst;
            c.wdata = res;
        end
        model_pc = next_pc;
        return c;
    endfunction

    // sampled on the falling edge of the memory cycle
    task automatic check_data_port(input commit_t exp);
        check_value("data_sram_en", data_sram_en, exp.ld || exp.st);
        check_value("data_sram_wen", data_sram_wen, exp.st ? 4'hf : 4'h0);
        if (exp.ld || exp.st) begin
            check_value("data_sram_addr", data_sram_addr, exp.mem_addr);
        end
        if (exp.st) begin
            check_value("data_sram_wdata", data_sram_wdata, exp.mem_data);
        end
    endtask

    // sampled on the falling edge of the writeback cycle
    task automatic check_commit(input commit_t exp);
        check_value("debug_wb_pc", debug_wb_pc, exp.pc);
        check_value("debug_wb_rf_wen", debug_wb_rf_wen, exp.wr ? 4'hf : 4'h0);
        if (exp.wr) begin
            check_value("debug_wb_rf_wnum", debug_wb_rf_wnum, exp.wnum);
            check_value("debug_wb_rf_wdata", debug_wb_rf_wdata, exp.wdata);
        end
    endtask

    // entered on the fetch cycle and returns on the next fetch cycle
    task automatic run_instruction();
        commit_t exp;
        int      cyc;
        check_value("inst_sram_addr", inst_sram_addr, model_pc);
        check_value("inst_sram_wen", inst_sram_wen, 4'h0);
        check_value("inst_sram_wdata", inst_sram_wdata, 32'h0);
        exp = ref_step(imem_words[model_pc[11:2]]);
        cyc = 0;
        do begin
            @(negedge clk);
            cyc++;
            if (cyc > gap_limit) begin
                abort_run("timeout: no next instruction fetch after a commit");
            end
            if (cyc == 3) begin
                check_data_port(exp);
            end else begin
                check_value("data_sram_en", data_sram_en, 1'b0);
            end
            if (cyc == 4) begin
                check_commit(exp);
            end else begin
                check_value("debug_wb_rf_wen", debug_wb_rf_wen, 4'h0);
            end
        end while (!inst_sram_en);
        check_value("fetch_interval", cyc, 5);
    endtask

    initial begin
        int unsigned seed;
        int          commits;
        int          self_loops;
        int          wait_cycles;
        logic [31:0] last_pc;
        seed = 32'h9f132aa0;
        void'($urandom(seed));
        rst_n = 1'b0;
        inst_sram_rdata = '0;
        data_sram_rdata = '0;

        // program image where unused slots hold nops
        for (int i = 0; i < 1024; i++) begin
            imem_words[i] = '0;
        end
        for (int i = 0; i < prog_len - 1; i++) begin
            imem_words[i] = random_instr(i, prog_len - 1);
        end
        last_pc = mycpu_pkg::reset_pc + 4 * (prog_len - 1);
        imem_words[prog_len - 1] = {mips_isa_pkg::op_j, last_pc[27:2]};

        // same random data image on both sides
        for (int i = 0; i < 256; i++) begin
            dmem_words[i] = $urandom;
            model_dmem[i] = dmem_words[i];
        end
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        model_pc = mycpu_pkg::reset_pc;

        // two cycles of reset with quiet outputs
        @(posedge clk);
        @(negedge clk);
        check_value("inst_sram_en", inst_sram_en, 1'b0);
        check_value("data_sram_en", data_sram_en, 1'b0);
        check_value("data_sram_wen", data_sram_wen, 4'h0);
        check_value("debug_wb_rf_wen", debug_wb_rf_wen, 4'h0);
        @(posedge clk);
        #1 rst_n = 1'b1;

        wait_cycles = 0;
        do begin
            @(negedge clk);
            wait_cycles++;
            if (wait_cycles > boot_limit) begin
                abort_run("timeout: no instruction fetch after reset");
            end
        end while (!inst_sram_en);

        // run to the final self jump and keep it looping a few times
        commits = 0;
        self_loops = 0;
        while (self_loops < 4) begin
            if (model_pc == last_pc) begin
                self_loops++;
            end
            run_instruction();
            commits++;
            if (commits > prog_len + 8) begin
                abort_run("program did not reach its final jump");
            end
        end

        $display("Test passed");
        $finish;
    end

endmodule

// ==== mycpu.f ====
hdl/mips_isa_pkg.sv
hdl/mycpu_pkg.sv
hdl/cpu_ifs.sv
hdl/regfile.sv
hdl/alu.sv
hdl/decoder.sv
hdl/datapath.sv
hdl/mycpu_top.sv
dv/tb_mycpu.sv

// ==== Bender.yml ====
package:
  name: mycpu

sources:
  - hdl/mips_isa_pkg.sv
  - hdl/mycpu_pkg.sv
  - hdl/cpu_ifs.sv
  - hdl/regfile.sv
  - hdl/alu.sv
  - hdl/decoder.sv
  - hdl/datapath.sv
  - hdl/mycpu_top.sv
  - target: test
    files:
      - dv/tb_mycpu.sv
